/* src/serv_decode_pkg.sv */
`default_nettype none

package serv_decode_pkg;

   // ------------------------------
   // instruction word layout
   // ------------------------------

   // word arrives without the two low bits
   localparam int INSTR_MSB  = 31;
   localparam int INSTR_LSB  = 2;

   localparam int OPCODE_LSB = 2;
   localparam int FUNCT3_LSB = 12;
   localparam int OP20_BIT   = 20;
   localparam int OP21_BIT   = 21;
   localparam int OP22_BIT   = 22;
   localparam int OP26_BIT   = 26;
   localparam int IMM30_BIT  = 30;

   // major opcodes from bits 6:2
   typedef enum logic [4:0] {
      opc_load   = 5'b00000,
      opc_op_imm = 5'b00100,
      opc_auipc  = 5'b00101,
      opc_store  = 5'b01000,
      opc_op     = 5'b01100,
      opc_lui    = 5'b01101,
      opc_branch = 5'b11000,
      opc_jalr   = 5'b11001,
      opc_jal    = 5'b11011,
      opc_system = 5'b11100
   } opcode_e;

   // ------------------------------
   // captured fields
   // ------------------------------

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] funct3;
      logic       imm30;
      // csr address bits and system sub-op
      logic       op20;
      logic       op21;
      logic       op22;
      logic       op26;
   } instr_fields_t;

   // ------------------------------
   // decoded control groups
   // ------------------------------

   // to state, ctrl and bufreg
   typedef struct packed {
      logic sh_right;
      logic bne_or_bge;
      logic cond_branch;
      logic e_op;
      logic ebreak;
      logic branch_op;
      logic shift_op;
      logic slt_or_branch;
      logic rd_op;
      logic two_stage_op;
      logic dbus_en;
      logic mtval_pc;
      logic bufreg_rs1_en;
      logic bufreg_imm_en;
      logic bufreg_clr_lsb;
      logic bufreg_sh_signed;
      logic jal_or_jalr;
      logic utype;
      logic pc_rel;
      logic rd_alu_en;
      logic rd_mem_en;
   } ctrl_dec_t;

   // to alu and mem interface
   typedef struct packed {
      logic       alu_sub;
      logic [1:0] alu_bool_op;
      logic       alu_cmp_eq;
      logic       alu_cmp_sig;
      logic [2:0] alu_rd_sel;
      logic       mem_signed;
      logic       mem_word;
      logic       mem_half;
      logic       mem_cmd;
   } alu_mem_dec_t;

   // to csr unit
   typedef struct packed {
      logic       csr_en;
      logic [1:0] csr_addr;
      logic       mstatus_en;
      logic       mie_en;
      logic       mcause_en;
      logic [1:0] csr_source;
      logic       csr_d_sel;
      logic       csr_imm_en;
      logic       rd_csr_en;
      logic       mret;
   } csr_dec_t;

   // to immediate decoder
   typedef struct packed {
      logic [3:0] immdec_ctrl;
      logic [3:0] immdec_en;
      logic       op_b_source;
   } immdec_dec_t;

endpackage

`default_nettype wire

/* src/decode_field_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_field_reg (
   input  wire                                                       clk,
   input  wire                                                       i_reset,
   input  wire                                                       i_wb_en,
   input  wire [serv_decode_pkg::INSTR_MSB:serv_decode_pkg::INSTR_LSB] i_wb_rdt,
   output serv_decode_pkg::instr_fields_t                            o_fields
);
   import serv_decode_pkg::*;

   instr_fields_t word_fields;

   // slice the incoming word
   always_comb begin
      word_fields.opcode = opcode_e'(i_wb_rdt[OPCODE_LSB +: $bits(opcode_e)]);
      word_fields.funct3 = i_wb_rdt[FUNCT3_LSB +: 3];
      word_fields.imm30  = i_wb_rdt[IMM30_BIT];
      word_fields.op20   = i_wb_rdt[OP20_BIT];
      word_fields.op21   = i_wb_rdt[OP21_BIT];
      word_fields.op22   = i_wb_rdt[OP22_BIT];
      word_fields.op26   = i_wb_rdt[OP26_BIT];
   end

   // capture on strobe, reset wins
   always_ff @(posedge clk) begin
      if (i_reset) begin
         // all-zero word decodes as lb
         o_fields.opcode <= opc_load;
         o_fields.funct3 <= 3'b000;
         o_fields.imm30  <= 1'b0;
         o_fields.op20   <= 1'b0;
         o_fields.op21   <= 1'b0;
         o_fields.op22   <= 1'b0;
         o_fields.op26   <= 1'b0;
      end else if (i_wb_en) begin
         o_fields <= word_fields;
      end
   end

   // decode must stay put between captures
   a_fields_hold : assert property (
      @(posedge clk) (!i_reset && !i_wb_en) |=> $stable(o_fields)
   );

endmodule

`default_nettype wire

/* src/exec_ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl_decode (
   input  wire serv_decode_pkg::instr_fields_t i_fields,
   output serv_decode_pkg::ctrl_dec_t          o_ctrl,
   output logic                                o_rd_op
);
   import serv_decode_pkg::*;

   logic [4:0] opc;
   logic [2:0] f3;
   logic       sys_op;

   assign opc    = i_fields.opcode;
   assign f3     = i_fields.funct3;
   // system space, bit 3 ignored
   assign sys_op = opc[4] & opc[2];

   always_comb begin
      // ------------------------------
      // state and sequencing
      // ------------------------------
      o_ctrl.sh_right      = f3[2];
      o_ctrl.bne_or_bge    = f3[0];
      o_ctrl.cond_branch   = ~opc[0];
      // ecall/ebreak only with funct3 zero and op21 low
      o_ctrl.e_op          = sys_op & ~i_fields.op21 & ~(|f3);
      o_ctrl.ebreak        = i_fields.op20;
      o_ctrl.branch_op     = opc[4];
      o_ctrl.shift_op      = opc[2] & ~f3[1];
      o_ctrl.slt_or_branch = opc[4] | (f3[1] & opc[2]) |
                             (i_fields.imm30 & opc[2] & opc[3] & ~f3[2]);
      // loads, stores, shifts and slt need a second pass
      o_ctrl.two_stage_op  = ~opc[2] |
                             (f3[0] & ~f3[1] & ~opc[0] & ~opc[4]) |
                             (f3[1] & ~f3[2] & ~opc[0] & ~opc[4]);
      // bus access for load and store
      o_ctrl.dbus_en       = ~opc[2] & ~opc[4];
      o_ctrl.mtval_pc      = opc[4];

      // rd written by alu/csr ops, jal/jalr and loads
      o_ctrl.rd_op         = opc[2] |
                             (~opc[2] & opc[4] & opc[0]) |
                             (~opc[2] & ~opc[3] & ~opc[0]);

      // ------------------------------
      // buffer register
      // ------------------------------
      o_ctrl.bufreg_rs1_en    = ~opc[4] | (~opc[1] & opc[0]);
      o_ctrl.bufreg_imm_en    = ~opc[2];
      // branch and jal targets are halfword aligned
      o_ctrl.bufreg_clr_lsb   = opc[4] & ((opc[1:0] == opc_branch[1:0]) |
                                          (opc[1:0] == opc_jal[1:0]));
      // arithmetic shift right
      o_ctrl.bufreg_sh_signed = i_fields.imm30;

      // ------------------------------
      // pc control
      // ------------------------------
      o_ctrl.jal_or_jalr = opc[4] & opc[0];
      // lui and auipc
      o_ctrl.utype       = ~opc[4] & opc[2] & opc[0];
      o_ctrl.pc_rel      = (opc[2:0] == opc_branch[2:0]) |
                           (opc[1:0] == opc_jal[1:0]) |
                           (sys_op & i_fields.op20) |
                           (opc[4:3] == 2'b00);

      // ------------------------------
      // write-back source
      // ------------------------------
      o_ctrl.rd_alu_en = ~opc[0] & opc[2] & ~opc[4];
      o_ctrl.rd_mem_en = ~opc[2] & ~opc[0];
   end

   // immediate decoder needs this too
   assign o_rd_op = o_ctrl.rd_op;

endmodule

`default_nettype wire

/* src/alu_mem_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_mem_decode (
   input  wire serv_decode_pkg::instr_fields_t i_fields,
   output serv_decode_pkg::alu_mem_dec_t       o_alu_mem
);
   import serv_decode_pkg::*;

   logic [4:0] opc;
   logic [2:0] f3;

   assign opc = i_fields.opcode;
   assign f3  = i_fields.funct3;

   always_comb begin
      // ------------------------------
      // alu
      // ------------------------------

      // sub for compares, branches and sub itself
      o_alu_mem.alu_sub     = f3[1] | f3[0] | (opc[3] & i_fields.imm30) | opc[4];
      // xor/or/and straight from funct3
      o_alu_mem.alu_bool_op = f3[1:0];
      // beq/bne
      o_alu_mem.alu_cmp_eq  = (f3[2:1] == 2'b00);
      // unsigned for sltu and bltu/bgeu
      o_alu_mem.alu_cmp_sig = ~((f3[0] & f3[1]) | (f3[1] & f3[2]));

      // result mux, one-hot
      // add/sub
      o_alu_mem.alu_rd_sel[0] = (f3 == 3'b000);
      // slt/sltu
      o_alu_mem.alu_rd_sel[1] = (f3[2:1] == 2'b01);
      // bool ops
      o_alu_mem.alu_rd_sel[2] = f3[2];

      // ------------------------------
      // memory interface
      // ------------------------------

      // lbu/lhu clear bit 2
      o_alu_mem.mem_signed = ~f3[2];
      o_alu_mem.mem_word   = f3[1];
      o_alu_mem.mem_half   = f3[0];
      // store differs from load in bit 3
      o_alu_mem.mem_cmd    = opc[3];
   end

endmodule

`default_nettype wire

/* src/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
   input  wire serv_decode_pkg::instr_fields_t i_fields,
   output serv_decode_pkg::csr_dec_t           o_csr,
   output logic                                o_csr_imm_en
);
   import serv_decode_pkg::*;

   logic [4:0] opc;
   logic [2:0] f3;
   logic       sys_op;
   logic       csr_op;
   logic       csr_valid;

   assign opc    = i_fields.opcode;
   assign f3     = i_fields.funct3;
   assign sys_op = opc[4] & opc[2];
   // csrrw..csrrci all have nonzero funct3
   assign csr_op = sys_op & (|f3);
   // address maps to an implemented register
   assign csr_valid = i_fields.op20 | (i_fields.op26 & ~i_fields.op21);

   always_comb begin
      o_csr.rd_csr_en  = csr_op;
      o_csr.csr_en     = csr_op & csr_valid;

      // ------------------------------
      // register select
      // ------------------------------
      // mstatus at 0x300, mie at 0x304
      o_csr.mstatus_en = csr_op & ~i_fields.op26 & ~i_fields.op22 & ~i_fields.op20;
      o_csr.mie_en     = csr_op & ~i_fields.op26 &  i_fields.op22 & ~i_fields.op20;
      o_csr.mcause_en  = csr_op & i_fields.op21 & ~i_fields.op20;
      // index into the rf csr slots
      o_csr.csr_addr   = {i_fields.op26 & i_fields.op20, ~i_fields.op26 | i_fields.op21};

      // ------------------------------
      // data source
      // ------------------------------
      // write/set/clear
      o_csr.csr_source = f3[1:0];
      o_csr.csr_d_sel  = f3[2];
      // zimm in place of rs1
      o_csr.csr_imm_en = sys_op & f3[2];

      // trap return
      o_csr.mret = sys_op & i_fields.op21 & ~(|f3);

      // one-hot register select
      a_mstatus_mie_excl : assert (!(o_csr.mstatus_en && o_csr.mie_en));
      // enables imply a csr access
      a_csr_en_rd : assert (
         !(o_csr.csr_en || o_csr.mstatus_en || o_csr.mie_en || o_csr.mcause_en) ||
         o_csr.rd_csr_en
      );
   end

   assign o_csr_imm_en = o_csr.csr_imm_en;

endmodule

`default_nettype wire

/* src/immdec_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module immdec_decode (
   input  wire serv_decode_pkg::instr_fields_t i_fields,
   input  wire                                 i_rd_op,
   input  wire                                 i_csr_imm_en,
   output serv_decode_pkg::immdec_dec_t        o_immdec
);
   import serv_decode_pkg::*;

   logic [4:0] opc;

   assign opc = i_fields.opcode;

   always_comb begin
      // ------------------------------
      // immediate format select
      // ------------------------------
      // store layout
      o_immdec.immdec_ctrl[0] = (opc[3:0] == opc_store[3:0]);
      o_immdec.immdec_ctrl[1] = (opc[1:0] == 2'b00) | (opc[2:1] == 2'b00);
      // branch and system
      o_immdec.immdec_ctrl[2] = opc[4] & ~opc[0];
      o_immdec.immdec_ctrl[3] = opc[4];

      // ------------------------------
      // immediate chunk enables
      // ------------------------------
      o_immdec.immdec_en[3] = opc[4] | opc[3] | opc[2] | ~opc[0];
      o_immdec.immdec_en[2] = (opc[4] & opc[2]) | ~opc[3] | opc[0];
      // csr zimm reuses the rs1 slot
      o_immdec.immdec_en[1] = (opc[2:1] == 2'b01) | (opc[2] & opc[0]) | i_csr_imm_en;
      // no rd means bits 11:7 hold immediate
      o_immdec.immdec_en[0] = ~i_rd_op;

      // rs2 for op and store/branch, else immediate
      o_immdec.op_b_source = opc[3];
   end

endmodule

`default_nettype wire

/* src/serv_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_decode_top (
   input  wire                                                       clk,
   input  wire                                                       i_reset,
   input  wire                                                       i_wb_en,
   input  wire [serv_decode_pkg::INSTR_MSB:serv_decode_pkg::INSTR_LSB] i_wb_rdt,
   output serv_decode_pkg::ctrl_dec_t                                o_ctrl,
   output serv_decode_pkg::alu_mem_dec_t                             o_alu_mem,
   output serv_decode_pkg::csr_dec_t                                 o_csr,
   output serv_decode_pkg::immdec_dec_t                              o_immdec
);
   import serv_decode_pkg::*;

   // ------------------------------
   // captured fields
   // ------------------------------
   instr_fields_t fields;

   // cross-group terms
   logic          rd_op;
   logic          csr_imm_en;

   decode_field_reg u_field_reg (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_wb_en  (i_wb_en),
      .i_wb_rdt (i_wb_rdt),
      .o_fields (fields)
   );

   // ------------------------------
   // group decoders
   // ------------------------------
   exec_ctrl_decode u_exec_ctrl (
      .i_fields (fields),
      .o_ctrl   (o_ctrl),
      .o_rd_op  (rd_op)
   );

   alu_mem_decode u_alu_mem (
      .i_fields  (fields),
      .o_alu_mem (o_alu_mem)
   );

   csr_decode u_csr (
      .i_fields     (fields),
      .o_csr        (o_csr),
      .o_csr_imm_en (csr_imm_en)
   );

   // rd_op and csr_imm_en come from their own groups
   immdec_decode u_immdec (
      .i_fields     (fields),
      .i_rd_op      (rd_op),
      .i_csr_imm_en (csr_imm_en),
      .o_immdec     (o_immdec)
   );

endmodule

`default_nettype wire

/* tests/tb_decode_model.svh */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// ------------------------------
// execution control group
// ------------------------------
function automatic ctrl_dec_t model_ctrl(input instr_fields_t f);
   ctrl_dec_t  c;
   logic [4:0] opc;
   logic [2:0] f3;
   logic       sys;
   opc = f.opcode;
   f3  = f.funct3;
   // system space, bit 3 is a don't care
   sys = opc[4] & opc[2];
   c.sh_right      = f3[2];
   c.bne_or_bge    = f3[0];
   c.cond_branch   = ~opc[0];
   c.e_op          = sys & ~f.op21 & (f3 == 3'b000);
   c.ebreak        = f.op20;
   c.branch_op     = opc[4];
   c.shift_op      = opc[2] & ~f3[1];
   c.slt_or_branch = opc[4] | (f3[1] & opc[2]) | (f.imm30 & opc[3] & opc[2] & ~f3[2]);
   // mem ops always, shifts and slt outside branch/system space
   c.two_stage_op  = ~opc[2] | (~opc[0] & ~opc[4] & ((f3[0] & ~f3[1]) | (f3[1] & ~f3[2])));
   c.dbus_en       = ~opc[4] & ~opc[2];
   c.mtval_pc      = opc[4];
   c.rd_op         = opc[2] | (opc[4] & opc[0]) | (~opc[3] & ~opc[0]);
   c.bufreg_rs1_en    = ~opc[4] | (~opc[1] & opc[0]);
   c.bufreg_imm_en    = ~opc[2];
   // branch 00 and jal 11 in the low bits
   c.bufreg_clr_lsb   = opc[4] & (opc[1] == opc[0]);
   c.bufreg_sh_signed = f.imm30;
   c.jal_or_jalr = opc[4] & opc[0];
   c.utype       = ~opc[4] & opc[2] & opc[0];
   c.pc_rel      = (opc[2:0] == 3'b000) | (opc[1:0] == 2'b11) | (sys & f.op20) |
                   (opc[4:3] == 2'b00);
   c.rd_alu_en   = ~opc[4] & opc[2] & ~opc[0];
   c.rd_mem_en   = ~opc[2] & ~opc[0];
   return c;
endfunction

// ------------------------------
// alu and memory group
// ------------------------------
function automatic alu_mem_dec_t model_alu_mem(input instr_fields_t f);
   alu_mem_dec_t a;
   logic [2:0]   f3;
   f3 = f.funct3;
   a.alu_sub     = f3[1] | f3[0] | (f.opcode[3] & f.imm30) | f.opcode[4];
   a.alu_bool_op = f3[1:0];
   a.alu_cmp_eq  = (f3[2:1] == 2'b00);
   // sltu, bltu and bgeu compare unsigned
   a.alu_cmp_sig = ~((f3[1] & f3[0]) | (f3[2] & f3[1]));
   a.alu_rd_sel  = {f3[2], f3[2:1] == 2'b01, f3 == 3'b000};
   a.mem_signed  = ~f3[2];
   a.mem_word    = f3[1];
   a.mem_half    = f3[0];
   a.mem_cmd     = f.opcode[3];
   return a;
endfunction

// ------------------------------
// csr group
// ------------------------------
function automatic csr_dec_t model_csr(input instr_fields_t f);
   csr_dec_t s;
   logic     sys;
   logic     csr_op;
   sys    = f.opcode[4] & f.opcode[2];
   csr_op = sys & (f.funct3 != 3'b000);
   s.rd_csr_en  = csr_op;
   s.csr_en     = csr_op & (f.op20 | (f.op26 & ~f.op21));
   s.mstatus_en = csr_op & ~f.op26 & ~f.op22 & ~f.op20;
   s.mie_en     = csr_op & ~f.op26 & f.op22 & ~f.op20;
   s.mcause_en  = csr_op & f.op21 & ~f.op20;
   s.csr_addr   = {f.op26 & f.op20, ~f.op26 | f.op21};
   s.csr_source = f.funct3[1:0];
   s.csr_d_sel  = f.funct3[2];
   s.csr_imm_en = sys & f.funct3[2];
   s.mret       = sys & f.op21 & (f.funct3 == 3'b000);
   return s;
endfunction

// ------------------------------
// immediate group
// ------------------------------
function automatic immdec_dec_t model_immdec(input instr_fields_t f);
   immdec_dec_t m;
   ctrl_dec_t   c;
   csr_dec_t    s;
   logic [4:0]  opc;
   opc = f.opcode;
   // shared terms come from the other two models
   c   = model_ctrl(f);
   s   = model_csr(f);
   m.immdec_ctrl[0] = (opc[3:0] == 4'b1000);
   m.immdec_ctrl[1] = (opc[1:0] == 2'b00) | (opc[2:1] == 2'b00);
   m.immdec_ctrl[2] = opc[4] & ~opc[0];
   m.immdec_ctrl[3] = opc[4];
   m.immdec_en[3]   = opc[4] | opc[3] | opc[2] | ~opc[0];
   m.immdec_en[2]   = (opc[4] & opc[2]) | ~opc[3] | opc[0];
   m.immdec_en[1]   = (opc[2:1] == 2'b01) | (opc[2] & opc[0]) | s.csr_imm_en;
   m.immdec_en[0]   = ~c.rd_op;
   m.op_b_source    = opc[3];
   return m;
endfunction

`endif

/* tests/tb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode;
   import serv_decode_pkg::*;

   // cycles allowed for a capture edge to show up
   localparam int WAIT_LIMIT = 16;

   logic         clk;
   logic         i_reset;
   logic         i_wb_en;
   logic [31:2]  i_wb_rdt;
   ctrl_dec_t    o_ctrl;
   alu_mem_dec_t o_alu_mem;
   csr_dec_t     o_csr;
   immdec_dec_t  o_immdec;

   integer       seed;
   int           checks;
   int           errors;
   int           test_start;
   logic [31:2]  last_word;

   `include "tb_decode_model.svh"

   serv_decode_top i_dut (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_wb_en   (i_wb_en),
      .i_wb_rdt  (i_wb_rdt),
      .o_ctrl    (o_ctrl),
      .o_alu_mem (o_alu_mem),
      .o_csr     (o_csr),
      .o_immdec  (o_immdec)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // own field slicing, rv32 bit positions
   function automatic instr_fields_t slice_word(input logic [31:2] w);
      instr_fields_t f;
      f.opcode = opcode_e'(w[6:2]);
      f.funct3 = w[14:12];
      f.imm30  = w[30];
      f.op20   = w[20];
      f.op21   = w[21];
      f.op22   = w[22];
      f.op26   = w[26];
      return f;
   endfunction

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_ctrl(input ctrl_dec_t got, input ctrl_dec_t exp, input string tag);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s ctrl group %h, expected %h", $time, tag, got, exp);
      end
   endtask

   task automatic check_alu_mem(input alu_mem_dec_t got, input alu_mem_dec_t exp,
                                input string tag);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s alu/mem group %h, expected %h", $time, tag, got, exp);
      end
   endtask

   task automatic check_csr(input csr_dec_t got, input csr_dec_t exp, input string tag);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s csr group %h, expected %h", $time, tag, got, exp);
      end
   endtask

   task automatic check_immdec(input immdec_dec_t got, input immdec_dec_t exp,
                               input string tag);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s immdec group %h, expected %h", $time, tag, got, exp);
      end
   endtask

   task automatic check_groups(input logic [31:2] word, input string tag);
      instr_fields_t f;
      f = slice_word(word);
      check_ctrl(o_ctrl, model_ctrl(f), tag);
      check_alu_mem(o_alu_mem, model_alu_mem(f), tag);
      check_csr(o_csr, model_csr(f), tag);
      check_immdec(o_immdec, model_immdec(f), tag);
   endtask

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   // rising edge with strobe high, bounded
   task automatic wait_capture();
      int   cycles;
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         seen = i_wb_en;
         cycles++;
      end
      if (!seen) begin
         $display("timeout: no capture edge within %0d cycles", WAIT_LIMIT);
         $display("Regression failed");
         $finish;
      end
   endtask

   // called on a falling edge, returns on the one after capture
   task automatic strobe_word(input logic [31:2] word, input string tag, input logic keep_en);
      i_wb_rdt  = word;
      i_wb_en   = 1'b1;
      last_word = word;
      wait_capture();
      @(negedge clk);
      i_wb_en = keep_en;
      check_groups(word, tag);
   endtask

   // half the words get a legal major opcode
   task automatic random_word(output logic [31:2] word);
      opcode_e opc;
      int      coin;
      int      pick;
      word = 30'($random(seed));
      coin = $random(seed);
      if (coin[0]) begin
         pick = $unsigned($random(seed)) % opc.num();
         opc  = opc.first();
         repeat (pick) opc = opc.next();
         word[6:2] = opc;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s done, %0d errors", name, errors - test_start);
      test_start = errors;
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      logic [31:2] word;
      int          idle;
      seed       = 31136;
      checks     = 0;
      errors     = 0;
      test_start = 0;
      i_reset    = 1'b1;
      i_wb_en    = 1'b0;
      i_wb_rdt   = '0;
      last_word  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_reset = 1'b0;

      // all-zero word after reset
      check_groups('0, "reset");
      end_test("reset");

      for (int n = 0; n < 2000; n++) begin
         random_word(word);
         strobe_word(word, "random", 1'b0);
      end
      end_test("random");

      // strobe low, bus noise must not leak through
      for (int r = 0; r < 20; r++) begin
         random_word(word);
         strobe_word(word, "hold", 1'b0);
         idle = 2 + ($unsigned($random(seed)) % 6);
         for (int c = 0; c < idle; c++) begin
            i_wb_rdt = 30'($random(seed));
            @(negedge clk);
            check_groups(last_word, "hold");
         end
      end
      end_test("hold");

      for (int n = 0; n < 300; n++) begin
         word      = 30'($random(seed));
         word[6:2] = opc_system;
         strobe_word(word, "system", 1'b0);
         checks++;
         if (o_csr.mstatus_en && o_csr.mie_en) begin
            errors++;
            $display("error at %0t ns: mstatus_en and mie_en both high", $time);
         end
      end
      end_test("system");

      // strobe high on every edge
      for (int n = 0; n < 200; n++) begin
         random_word(word);
         strobe_word(word, "back-to-back", 1'b1);
      end
      i_wb_en = 1'b0;
      end_test("back-to-back");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+tests
src/serv_decode_pkg.sv
src/decode_field_reg.sv
src/exec_ctrl_decode.sv
src/alu_mem_decode.sv
src/csr_decode.sv
src/immdec_decode.sv
src/serv_decode_top.sv
tests/tb_decode.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decoder testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module tb_decode \
      -Mdir obj_dir -o tb_decode; then
   echo "build failed"
   exit 1
fi

if ! ./obj_dir/tb_decode > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "^Regression passed$" sim.log; then
   exit 0
fi
exit 1
